// ==== build.f ====
hdl/lcd_pkg.sv
hdl/lcd_req_if.sv
hdl/lcd_bus_ctrl.sv
hdl/lcd_arbiter.sv
hdl/lcd_text_writer.sv
hdl/lcd_cursor_writer.sv
hdl/lcd_subsys_top.sv
test/lcd_subsys_sva.sv
test/lcd_subsys_tb.sv

// ==== Makefile ====
# Verilator flow for the LCD write subsystem

VERILATOR ?= verilator
TOP       ?= lcd_subsys_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/lcd_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_tb import lcd_pkg::*; ();

	localparam int CLK_PERIOD  = 8;
	localparam int N_ITEMS     = 80;
	localparam int INIT_CYCLES = POWERUP_CYCLES + 4 * INIT_PULSE + INIT_WAIT_FS + INIT_WAIT_DC
		+ INIT_WAIT_CLR + INIT_WAIT_EM;
	localparam int WATCHDOG_CYCLES = 3 * (INIT_CYCLES + N_ITEMS * WR_TOTAL);

	logic             clk;
	logic             rst_n;
	logic [CFG_W-1:0] cfg;
	logic             char_valid;
	logic [7:0]       char_code;
	logic             full;
	logic             pos_valid;
	logic             row;
	logic [5:0]       col;
	logic             pending;
	logic             lcd_e;
	logic             lcd_rs;
	logic             lcd_rw;
	logic [7:0]       lcd_data;
	logic             lcd_busy;

	logic [31:0] seed;
	logic [7:0]  chars [$];     // accepted and not yet granted
	logic [8:0]  exp_words [$]; // granted {rs, data} not yet on the bus
	logic        m_pend;
	logic [7:0]  m_instr;
	logic        m_last_cur;
	int          m_busy_left;   // busy cycles still to come
	int          cyc;           // edges since reset release
	int          n_pulse;
	int          e_len;
	logic        e_q;
	logic        init_seen;

	lcd_subsys_top i_lcd_subsys_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// the four init codes built from the panel setup word
	function automatic logic [7:0] init_code(input int idx, input logic [CFG_W-1:0] c);
		case (idx)
			0:       return {4'b0011, c[6], c[5], 2'b00};
			1:       return {5'b00001, c[4], c[3], c[2]};
			2:       return 8'h01;
			default: return {6'b000001, c[1], c[0]};
		endcase
	endfunction

	function automatic logic [7:0] ddram_instr(input logic r, input logic [5:0] c);
		return INSTR_SET_DDRAM + LINE2_OFFSET * {7'd0, r} + {2'b00, c};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else abort_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_transfer();
		logic [8:0] w;
		int         idx;
		idx = n_pulse;
		n_pulse++;
		check_value("lcd_rw", lcd_rw, 0);
		if (idx < 4) begin
			check_value("lcd_rs", lcd_rs, 0);
			check_value("lcd_data", lcd_data, init_code(idx, cfg));
		end else if (exp_words.size() == 0) begin
			abort_run("a write appeared on lcd_e with nothing granted in the model");
		end else begin
			w = exp_words.pop_front();
			check_value("lcd_rs", lcd_rs, w[8]);
			check_value("lcd_data", lcd_data, w[7:0]);
		end
	endtask

	// model runs on values from before the edge
	always @(posedge clk) begin
		logic t_req;
		logic c_req;
		logic was_full;
		logic cur_won;
		logic txt_won;
		if (!rst_n) begin
			chars.delete();
			exp_words.delete();
			m_pend      = 1'b0;
			m_instr     = 8'h00;
			m_last_cur  = 1'b1; // text wins the first tie
			m_busy_left = INIT_CYCLES;
			cyc         = 0;
			n_pulse     = 0;
			e_len       = 0;
			e_q         = 1'b0;
			init_seen   = 1'b0;
		end else begin
			if (cyc == 0) begin
				check_value("lcd_busy", lcd_busy, 1);
				check_value("lcd_e", lcd_e, 0);
				check_value("lcd_rs", lcd_rs, 0);
				check_value("lcd_rw", lcd_rw, 0);
				check_value("lcd_data", lcd_data, 0);
			end
			if (!init_seen && !lcd_busy) begin
				check_value("init cycles", cyc, INIT_CYCLES);
				check_value("init pulses", n_pulse, 4);
				init_seen = 1'b1;
			end
			check_value("lcd_busy", lcd_busy, m_busy_left != 0);
			check_value("full", full, chars.size() == TXT_DEPTH);
			check_value("pending", pending, m_pend);
			if (lcd_e && !e_q)
				check_transfer();
			if (!lcd_e && e_q)
				check_value("lcd_e high cycles", e_len, (n_pulse <= 4) ? INIT_PULSE : WR_HIGH);
			e_len = lcd_e ? e_len + 1 : 0;
			e_q   = lcd_e;

			t_req    = chars.size() != 0;
			c_req    = m_pend;
			was_full = chars.size() == TXT_DEPTH;
			cur_won  = 1'b0;
			if ((t_req || c_req) && m_busy_left == 0) begin // grants only on an idle bus
				if (t_req && c_req)
					txt_won = m_last_cur; // the one not served last
				else
					txt_won = t_req;
				if (txt_won) begin
					exp_words.push_back({1'b1, chars.pop_front()});
					m_last_cur = 1'b0;
				end else begin
					exp_words.push_back({1'b0, m_instr});
					m_last_cur = 1'b1;
					cur_won    = 1'b1;
				end
				m_busy_left = WR_TOTAL;
			end else if (m_busy_left != 0) begin
				m_busy_left--;
			end
			if (char_valid && !was_full)
				chars.push_back(char_code); // strobe while full is lost
			if (pos_valid) begin
				m_instr = ddram_instr(row, col);
				m_pend  = 1'b1;
			end else if (cur_won) begin
				m_pend = 1'b0;
			end
			cyc++;
		end
	end

	initial begin
		logic [1:0] kind;
		clk        = 1'b0;
		rst_n      = 1'b0;
		char_valid = 1'b0;
		char_code  = 8'h00;
		pos_valid  = 1'b0;
		row        = 1'b0;
		col        = 6'd0;
		seed       = 32'hd609;
		seed       = lcg_next(seed);
		cfg        = seed[30:24]; // panel setup for the whole run
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < N_ITEMS; i++) begin
			seed = lcg_next(seed);
			kind = seed[31:30];
			@(posedge clk);
			char_valid <= (kind != 2'd0);
			char_code  <= seed[23:16];
			pos_valid  <= (kind <= 2'd1); // kind 1 strobes both
			row        <= seed[15];
			col        <= seed[13:8];
			@(posedge clk);
			char_valid <= 1'b0;
			pos_valid  <= 1'b0;
			repeat (seed[29:24]) @(posedge clk);
		end
		do
			@(negedge clk);
		while (chars.size() != 0 || m_pend || lcd_busy);
		if (exp_words.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			abort_run("the bus went idle before every granted item appeared on lcd_e");
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("watchdog expired before all transfers finished");
	end

endmodule

`default_nettype wire

// ==== test/lcd_subsys_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_sva import lcd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic e,
	input logic rw,
	input logic busy
);

	localparam int FALL_AT = WR_SETUP + WR_HIGH + 1; // samples from start to enable low again

	a_e_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) e |-> busy)
		else $error("lcd enable high while the controller is idle");

	a_rw_low: assert property (@(posedge clk) disable iff (!rst_n) !rw)
		else $error("lcd rw driven high");

	// setup cycle low before the pulse, low again after it
	a_e_frame: assert property (@(posedge clk) disable iff (!rst_n)
		$past(start && !busy, FALL_AT) |-> !e && !$past(e, FALL_AT - 1))
		else $error("write enable pulse framed wrongly");

	for (genvar k = 1; k <= WR_HIGH; k++) begin : g_e_high
		a_e_high: assert property (@(posedge clk) disable iff (!rst_n)
			$past(start && !busy, FALL_AT) |-> $past(e, k))
			else $error("write enable pulse dropped early");
	end

endmodule

bind lcd_bus_ctrl lcd_subsys_sva i_lcd_subsys_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.start (start),
	.e     (e),
	.rw    (rw),
	.busy  (busy)
);

`default_nettype wire

// ==== hdl/lcd_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_subsys_top import lcd_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [CFG_W-1:0] cfg,
	input  logic             char_valid,
	input  logic [7:0]       char_code,
	output logic             full,
	input  logic             pos_valid,
	input  logic             row,
	input  logic [5:0]       col,
	output logic             pending,
	output logic             lcd_e,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic [7:0]       lcd_data,
	output logic             lcd_busy
);

	logic       ctrl_start;
	logic [9:0] ctrl_word;

	lcd_req_if txt_if ();
	lcd_req_if cur_if ();

	lcd_text_writer i_lcd_text_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.char_valid (char_valid),
		.char_code  (char_code),
		.full       (full),
		.bus        (txt_if.requester)
	);

	lcd_cursor_writer i_lcd_cursor_writer (
		.clk       (clk),
		.rst_n     (rst_n),
		.pos_valid (pos_valid),
		.row       (row),
		.col       (col),
		.pending   (pending),
		.bus       (cur_if.requester)
	);

	lcd_arbiter i_lcd_arbiter (
		.clk   (clk),
		.rst_n (rst_n),
		.txt   (txt_if.arbiter),
		.cur   (cur_if.arbiter),
		.busy  (lcd_busy),
		.start (ctrl_start),
		.word  (ctrl_word)
	);

	lcd_bus_ctrl i_lcd_bus_ctrl (
		.clk   (clk),
		.rst_n (rst_n),
		.cfg   (cfg),
		.start (ctrl_start),
		.word  (ctrl_word),
		.e     (lcd_e),
		.rs    (lcd_rs),
		.rw    (lcd_rw),
		.data  (lcd_data),
		.busy  (lcd_busy)
	);

endmodule

`default_nettype wire

// ==== hdl/lcd_cursor_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_cursor_writer import lcd_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         pos_valid,
	input  logic         row,
	input  logic [5:0]   col,
	output logic         pending,
	lcd_req_if.requester bus
);

	logic [7:0] instr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (pos_valid)
			pending <= 1'b1; // a new move beats a same-cycle grant
		else if (bus.grant)
			pending <= 1'b0;
	end

	// later request overwrites an ungranted one
	always_ff @(posedge clk) begin
		if (pos_valid)
			instr <= INSTR_SET_DDRAM + (row ? LINE2_OFFSET : 8'h00) + {2'b00, col};
	end

	assign bus.req  = pending;
	assign bus.rs   = 1'b0; // instruction register
	assign bus.data = instr;

endmodule

`default_nettype wire

// ==== hdl/lcd_text_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_text_writer import lcd_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         char_valid,
	input  logic [7:0]   char_code,
	output logic         full,
	lcd_req_if.requester bus
);

	logic [7:0]                   mem [TXT_DEPTH];
	logic [$clog2(TXT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(TXT_DEPTH)-1:0] rd_ptr;
	logic [$clog2(TXT_DEPTH):0]   count;
	logic                         push;
	logic                         pop;

	assign full = (count == TXT_DEPTH);
	assign push = char_valid && !full; // dropped when full
	assign pop  = bus.grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= char_code;
	end

	assign bus.req  = (count != '0);
	assign bus.rs   = 1'b1; // character data
	assign bus.data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/lcd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_arbiter import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	lcd_req_if.arbiter txt,
	lcd_req_if.arbiter cur,
	input  logic       busy,
	output logic       start,
	output logic [9:0] word
);

	logic [NUM_REQ-1:0] req_vec;
	logic               last_cur; // cursor writer was served last
	logic               pick_txt;

	assign req_vec = {cur.req, txt.req};

	// text wins unless cursor also waits and text went last
	assign pick_txt = txt.req && (!cur.req || last_cur);

	assign start = (|req_vec) && !busy;

	assign txt.grant = start && pick_txt;
	assign cur.grant = start && !pick_txt;

	// rw is always a write
	always_comb begin
		if (pick_txt)
			word = {txt.rs, 1'b0, txt.data};
		else
			word = {cur.rs, 1'b0, cur.data};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_cur <= 1'b1; // text wins the first tie
		else if (start)
			last_cur <= !pick_txt;
	end

endmodule

`default_nettype wire

// ==== hdl/lcd_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_ctrl import lcd_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [CFG_W-1:0] cfg,
	input  logic             start,
	input  logic [9:0]       word,  // {rs, rw, data}
	output logic             e,
	output logic             rs,
	output logic             rw,
	output logic [7:0]       data,
	output logic             busy
);

	typedef enum logic [1:0] {
		st_power,
		st_init,
		st_idle,
		st_write
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [CFG_W-1:0] cfg_q;
	logic [9:0]       word_q;

	// one counter shared by all timed phases
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_power;
			cnt   <= '0;
		end else begin
			case (state)
				st_power: begin
					if (cnt == CNT_W'(POWERUP_CYCLES - 1)) begin
						state <= st_init;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_init: begin
					if (cnt == CNT_W'(INIT_DONE - 1)) begin
						state <= st_idle;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_idle: begin
					if (start) begin
						state <= st_write;
						cnt   <= '0;
					end
				end
				default: begin
					if (cnt == CNT_W'(WR_TOTAL - 1)) begin
						state <= st_idle; // transfer slot over
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_power && cnt == CNT_W'(POWERUP_CYCLES - 1))
			cfg_q <= cfg; // panel setup taken once
		if (state == st_idle && start)
			word_q <= word;
	end

	always_comb begin
		e    = 1'b0;
		rs   = 1'b0;
		rw   = 1'b0;
		data = 8'h00;
		busy = 1'b1;
		case (state)
			st_init: begin
				if (cnt < INIT_PULSE) begin
					e    = 1'b1;
					data = {4'b0011, cfg_q[6], cfg_q[5], 2'b00}; // function set
				end else if (cnt >= INIT_DC_AT && cnt < INIT_DC_AT + INIT_PULSE) begin
					e    = 1'b1;
					data = {5'b00001, cfg_q[4], cfg_q[3], cfg_q[2]}; // display control
				end else if (cnt >= INIT_CLR_AT && cnt < INIT_CLR_AT + INIT_PULSE) begin
					e    = 1'b1;
					data = 8'b0000_0001; // clear
				end else if (cnt >= INIT_EM_AT && cnt < INIT_EM_AT + INIT_PULSE) begin
					e    = 1'b1;
					data = {6'b000001, cfg_q[1], cfg_q[0]}; // entry mode
				end
			end
			st_idle: busy = 1'b0;
			st_write: begin
				rs   = word_q[9];
				rw   = word_q[8];
				data = word_q[7:0];
				e    = (cnt >= WR_SETUP) && (cnt < WR_SETUP + WR_HIGH);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/lcd_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one write request from a requester towards the arbiter
interface lcd_req_if;

	logic       req;   // level, held until granted
	logic       rs;    // register select
	logic [7:0] data;
	logic       grant; // one-cycle pulse back

	modport requester (
		output req,
		output rs,
		output data,
		input  grant
	);

	modport arbiter (
		input  req,
		input  rs,
		input  data,
		output grant
	);

endinterface

`default_nettype wire

// ==== hdl/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

	// power-up and init timing, one count per clock
	localparam int POWERUP_CYCLES = 500;
	localparam int INIT_PULSE     = 10;
	localparam int INIT_WAIT_FS   = 50;  // after function set
	localparam int INIT_WAIT_DC   = 50;  // after display control
	localparam int INIT_WAIT_CLR  = 200; // clear needs the long wait
	localparam int INIT_WAIT_EM   = 100; // after entry mode

	// start of each init pulse within the init phase
	localparam int INIT_DC_AT  = INIT_PULSE + INIT_WAIT_FS;
	localparam int INIT_CLR_AT = INIT_DC_AT + INIT_PULSE + INIT_WAIT_DC;
	localparam int INIT_EM_AT  = INIT_CLR_AT + INIT_PULSE + INIT_WAIT_CLR;
	localparam int INIT_DONE   = INIT_EM_AT + INIT_PULSE + INIT_WAIT_EM;

	// single write transfer phases
	localparam int WR_SETUP = 1;
	localparam int WR_HIGH  = 13;
	localparam int WR_TOTAL = 51;

	// wide enough for the power-up wait
	localparam int CNT_W = 9;

	// {lines, font, display on, cursor, blink, increment, shift}
	localparam int CFG_W = 7;

	localparam int TXT_DEPTH = 4;
	localparam int NUM_REQ   = 2;

	localparam logic [7:0] INSTR_SET_DDRAM = 8'h80;
	localparam logic [7:0] LINE2_OFFSET    = 8'h40;

endpackage

`default_nettype wire
